//--- dv/frontend_stimulus.txt
# stall pc_sel target hdr_dly resp_dly rtype instr exp_addr exp_instr, all hex
# delay f is random 1..8; rtype 7 wakes the port first, 4 adds a store ack, 0 is a load return
00 0 00000000 0 1 7 00100093 40000000 00100093
00 0 00000000 1 2 1 00200113 40000004 00200113
00 0 00000000 0 0 0 00308193 40000008 00308193
00 2 40000100 2 3 1 00418213 4000000c 00418213
00 0 00000000 1 1 4 00520293 40000100 00520293
00 3 00000000 0 2 1 00628313 40000104 00628313
00 0 00000000 1 1 1 00730393 40000104 00730393
08 0 00000000 0 2 1 00838413 40000108 00838413
00 1 00000000 0 1 1 00940493 4000010c 00940493
00 0 00000000 f f 1 00a48513 40000000 00a48513
0c 0 00000000 f f 4 00b50593 40000004 00b50593
00 2 40000200 f f 1 00c58613 40000008 00c58613
00 0 00000000 f f 0 00d60693 40000200 00d60693
00 0 00000000 f 0 1 00e68713 40000204 00e68713
03 0 00000000 0 5 1 00f70793 40000208 00f70793
00 3 00000000 f f 1 01078813 4000020c 01078813
00 0 00000000 f f 1 01180893 4000020c 01180893
00 2 40000040 f f 1 01288913 40000210 01288913
00 0 00000000 f f 4 01390993 40000040 01390993
0a 0 00000000 f 2 1 01498a13 40000044 01498a13
00 0 00000000 0 0 1 015a0a93 40000048 015a0a93
00 0 00000000 0 0 0 016a8b13 4000004c 016a8b13
00 2 40001000 f f 1 017b0b93 40000050 017b0b93
00 1 00000000 f f 1 018b8c13 40001000 018b8c13
00 0 00000000 f f 1 019c0c93 40000000 019c0c93
0c 3 00000000 f f 1 01ac8d13 40000004 01ac8d13
00 0 00000000 f f 4 01bd0d93 40000004 01bd0d93
00 0 00000000 2 4 1 01cd8e13 40000008 01cd8e13
00 2 40000ffc f f 1 01de0e93 4000000c 01de0e93
00 0 00000000 f f 1 01ee8f13 40000ffc 01ee8f13

//--- frontend_top.f
rtl/frontend_pkg.sv
rtl/pc_unit.sv
rtl/l15_fetch_port.sv
rtl/fetch_output.sv
rtl/frontend_top.sv
dv/frontend_tb.sv

//--- Bender.yml
package:
  name: frontend_top

sources:
  - files:
      - rtl/frontend_pkg.sv
      - rtl/pc_unit.sv
      - rtl/l15_fetch_port.sv
      - rtl/fetch_output.sv
      - rtl/frontend_top.sv
  - target: simulation
    files:
      - dv/frontend_tb.sv

//--- dv/frontend_tb.sv
`timescale 1ns/1ps

module frontend_tb
	import frontend_pkg::*;
();

	// one line of the stimulus file
	typedef struct packed
	{
		logic [7:0]  stall_len;   // stall cycles from the wait state on
		logic [1:0]  pc_sel;
		logic [31:0] target;
		logic [3:0]  hdr_dly;     // f picks a random delay
		logic [3:0]  resp_dly;
		logic [3:0]  rtype;       // 7 wakes first, 4 adds a store ack
		logic [31:0] instr;
		logic [31:0] exp_addr;
		logic [31:0] exp_instr;
	} step_t;

	logic       clk;
	logic       nrst;
	logic       stall;
	redirect_t  redirect;
	l15_req_t   l15_req;
	logic       l15_header_ack;
	logic       l15_ack;
	l15_resp_t  l15_resp;
	logic       l15_req_ack;
	fetch_out_t fetch_out;

	step_t       steps[$];
	fetch_out_t  exp_q[$];       // results the DUT still owes
	logic [31:0] lfsr;
	logic        steps_loaded;
	logic        mon_on;
	logic        stall_seen;     // stall as the next edge samples it
	logic        fill_due;       // a fill return was taken, its result is owed
	fetch_out_t  last_out;
	int          req_errors;
	int          fetch_errors;
	int          ack_errors;
	int          other_errors;

	frontend_top u_dut
	(
		.clk            (clk),
		.nrst           (nrst),
		.stall          (stall),
		.redirect       (redirect),
		.l15_req        (l15_req),
		.l15_header_ack (l15_header_ack),
		.l15_ack        (l15_ack),
		.l15_resp       (l15_resp),
		.l15_req_ack    (l15_req_ack),
		.fetch_out      (fetch_out)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#5 clk = ~clk;
		end
	end

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic int delay_of(input logic [3:0] code);
		if (code == 4'hf)
			return 1 + int'(rand_bits(3));   // 1 to 8
		return int'(code);
	endfunction

	task automatic check_req(input l15_req_t got, input l15_req_t exp);
		if (got !== exp)
		begin
			req_errors++;
			$display("Fail at %0t: l15_req got %b/%h/%h/%h expected %b/%h/%h/%h", $time,
				got.val, got.rqtype, got.size, got.address,
				exp.val, exp.rqtype, exp.size, exp.address);
		end
	endtask

	task automatic check_fetch(input fetch_out_t got, input fetch_out_t exp);
		if (got !== exp)
		begin
			fetch_errors++;
			$display("Fail at %0t: fetch_out got %b/%h/%h expected %b/%h/%h", $time,
				got.valid, got.pc, got.instr, exp.valid, exp.pc, exp.instr);
		end
	endtask

	task automatic check_ack(input logic got, input logic exp);
		if (got !== exp)
		begin
			ack_errors++;
			$display("Fail at %0t: l15_req_ack got %b expected %b", $time, got, exp);
		end
	endtask

	// one return cycle, called 1 ns after a rising edge
	task automatic send_resp(input l15_ret_e rtype, input logic [31:0] word0);
		l15_resp.val        = 1'b1;
		l15_resp.returntype = rtype;
		l15_resp.data[0]    = word0;
		for (int i = 1; i < 4; i++)
			l15_resp.data[i] = rand_bits(32);   // unused words get noise
		@(posedge clk);
		#1;
		l15_resp.val = 1'b0;
	endtask

	task automatic wake_port(input logic [31:0] addr);
		l15_req_t asleep;
		asleep = '{val: 1'b0, rqtype: rq_ifill, size: fetch_size, address: addr};
		repeat (4)
		begin
			@(negedge clk);
			check_req(l15_req, asleep);
		end
		@(posedge clk);
		#1;
		send_resp(ret_st_ack, rand_bits(32));
		@(negedge clk);
		check_req(l15_req, asleep);   // a store ack must not wake the port
		@(posedge clk);
		#1;
		send_resp(ret_int, rand_bits(32));
	endtask

	task automatic drive_stall(input int cycles);
		stall = 1'b1;
		repeat (cycles) @(posedge clk);
		#1;
		stall = 1'b0;
	endtask

	task automatic answer_fill(input step_t s);
		int       d;
		l15_ret_e fill_type;
		fill_type = (s.rtype == 4'h0) ? ret_load : ret_ifill;
		if (s.rtype == 4'h4)
			send_resp(ret_st_ack, rand_bits(32));
		d = delay_of(s.resp_dly);
		repeat (d) @(posedge clk);
		if (d > 0)
			#1;
		send_resp(fill_type, s.instr);
	endtask

	task automatic run_step(input step_t s, input int idx);
		l15_req_t want;
		int       waited;
		logic     seen;
		want = '{val: 1'b1, rqtype: rq_ifill, size: fetch_size, address: s.exp_addr};
		redirect.pc_sel = pc_sel_e'(s.pc_sel);   // held until after the response state
		redirect.target = s.target;
		if (s.rtype == 4'h7)
			wake_port(s.exp_addr);
		exp_q.push_back('{valid: 1'b1, pc: s.exp_addr, instr: s.exp_instr});
		seen   = 1'b0;
		waited = 0;
		while (!seen && waited < 64)
		begin
			@(negedge clk);
			seen = l15_req.val;
			waited++;
		end
		if (!seen)
		begin
			other_errors++;
			$display("step %0d: no fill request raised within 64 cycles", idx);
		end
		else
		begin
			check_req(l15_req, want);
			repeat (delay_of(s.hdr_dly))
			begin
				@(negedge clk);
				check_req(l15_req, want);   // request must hold still until taken
			end
			@(posedge clk);
			#1;
			l15_header_ack = 1'b1;
			@(posedge clk);
			#1;
			l15_header_ack = 1'b0;
			fork
				if (s.stall_len != 0)
					drive_stall(s.stall_len);
				answer_fill(s);
			join
			@(posedge clk);
			#1;
		end
	endtask

	// output side, sampled mid cycle
	always @(negedge clk)
	begin
		fetch_out_t want;
		l15_req_t   idle;
		if (mon_on)
		begin
			// result is due at the first edge with stall low after its return
			if (fill_due && !stall_seen)
			begin
				if (!fetch_out.valid)
				begin
					other_errors++;
					$display("fetch result missing at %0t after its fill return", $time);
				end
				fill_due = 1'b0;
			end
			if (stall_seen)
				check_fetch(fetch_out, last_out);   // frozen by the last edge
			else if (fetch_out.valid && exp_q.size() == 0)
			begin
				other_errors++;
				$display("unexpected fetch result at %0t, pc %h", $time, fetch_out.pc);
			end
			else if (fetch_out.valid)
			begin
				want = exp_q.pop_front();
				check_fetch(fetch_out, want);
			end
			else
			begin
				want       = fetch_out;
				want.instr = nop_instr;
				check_fetch(fetch_out, want);
			end
			if (stall)
			begin
				idle     = l15_req;
				idle.val = 1'b0;
				check_req(l15_req, idle);
			end
			check_ack(l15_req_ack, l15_resp.val);   // every return acked in its own cycle
			if (l15_resp.val &&
				(l15_resp.returntype == ret_load || l15_resp.returntype == ret_ifill))
				fill_due = 1'b1;
			stall_seen = stall;
			last_out   = fetch_out;
		end
	end

	initial
	begin
		wait (steps_loaded);
		#((steps.size() + 1) * 64 * 10);
		$display("watchdog expired, fetch sequence stuck after %0d lines", steps.size());
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		int          fd;
		int          n;
		string       line;
		logic [7:0]  f_stall;
		logic [1:0]  f_sel;
		logic [31:0] f_target;
		logic [3:0]  f_hdr;
		logic [3:0]  f_resp;
		logic [3:0]  f_type;
		logic [31:0] f_instr;
		logic [31:0] f_addr;
		logic [31:0] f_exp;
		nrst           = 1'b0;
		stall          = 1'b0;
		redirect       = '0;
		l15_header_ack = 1'b0;
		l15_ack        = 1'b0;   // fills are header only
		l15_resp       = '0;
		lfsr           = 32'h5bd035da;
		steps_loaded   = 1'b0;
		mon_on         = 1'b0;
		stall_seen     = 1'b0;
		fill_due       = 1'b0;
		last_out       = '0;
		req_errors     = 0;
		fetch_errors   = 0;
		ack_errors     = 0;
		other_errors   = 0;
		fd = $fopen("dv/frontend_stimulus.txt", "r");
		if (fd == 0)
		begin
			other_errors++;
			$display("cannot open dv/frontend_stimulus.txt");
		end
		else
		begin
			while (!$feof(fd))
			begin
				n = $fgets(line, fd);
				if (n > 0 && line.len() > 1 && line[0] != "#")
				begin
					n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", f_stall, f_sel, f_target,
						f_hdr, f_resp, f_type, f_instr, f_addr, f_exp);
					if (n == 9)
						steps.push_back({f_stall, f_sel, f_target, f_hdr, f_resp, f_type,
							f_instr, f_addr, f_exp});
					else
					begin
						other_errors++;
						$display("malformed stimulus line: %s", line);
					end
				end
			end
			$fclose(fd);
		end
		steps_loaded = 1'b1;
		repeat (5) @(posedge clk);
		#1;
		nrst   = 1'b1;
		mon_on = 1'b1;
		foreach (steps[i])
			run_step(steps[i], i);
		repeat (4) @(posedge clk);
		if (exp_q.size() != 0)
		begin
			other_errors += exp_q.size();
			$display("%0d expected fetch results never appeared", exp_q.size());
		end
		$display("errors: req %0d, fetch %0d, ack %0d, other %0d",
			req_errors, fetch_errors, ack_errors, other_errors);
		if (req_errors + fetch_errors + ack_errors + other_errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- rtl/frontend_top.sv
`timescale 1ns/1ps

module frontend_top
	import frontend_pkg::*;
(
	input  logic       clk,
	input  logic       nrst,
	input  logic       stall,          // decode back-pressure
	input  redirect_t  redirect,
	output l15_req_t   l15_req,
	input  logic       l15_header_ack,
	input  logic       l15_ack,
	input  l15_resp_t  l15_resp,
	output logic       l15_req_ack,
	output fetch_out_t fetch_out
);

	logic        pc_advance;   // one pulse per completed fetch
	logic [31:0] req_pc;
	logic [31:0] fetched_pc;
	fetch_word_t resp_word;

	pc_unit u_pc_unit
	(
		.clk        (clk),
		.nrst       (nrst),
		.redirect   (redirect),
		.pc_advance (pc_advance),
		.req_pc     (req_pc),
		.fetched_pc (fetched_pc)
	);

	// cache side
	l15_fetch_port u_l15_fetch_port
	(
		.clk            (clk),
		.nrst           (nrst),
		.stall          (stall),
		.req_pc         (req_pc),
		.l15_req        (l15_req),
		.l15_header_ack (l15_header_ack),
		.l15_ack        (l15_ack),
		.l15_resp       (l15_resp),
		.l15_req_ack    (l15_req_ack),
		.pc_advance     (pc_advance),
		.resp_word      (resp_word)
	);

	// decode side
	fetch_output u_fetch_output
	(
		.clk        (clk),
		.nrst       (nrst),
		.stall      (stall),
		.fetched_pc (fetched_pc),
		.resp_word  (resp_word),
		.fetch_out  (fetch_out)
	);

endmodule

//--- rtl/fetch_output.sv
`timescale 1ns/1ps

module fetch_output
	import frontend_pkg::*;
(
	input  logic        clk,
	input  logic        nrst,
	input  logic        stall,
	input  logic [31:0] fetched_pc,
	input  fetch_word_t resp_word,
	output fetch_out_t  fetch_out
);

	// one result parked while decode is stalled
	logic        hold_valid;
	logic [31:0] hold_pc;
	logic [31:0] hold_instr;
	logic        hold_load;

	// park a new result when it cannot go straight out
	assign hold_load = resp_word.valid && (stall || hold_valid);

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			hold_valid <= 1'b0;
			fetch_out  <= '{valid: 1'b0, pc: reset_vector, instr: nop_instr};
		end
		else if (stall)
		begin
			// output frozen, only the buffer can fill
			if (resp_word.valid)
			begin
				hold_valid <= 1'b1;
			end
		end
		else if (hold_valid)
		begin
			fetch_out  <= '{valid: 1'b1, pc: hold_pc, instr: hold_instr};
			hold_valid <= resp_word.valid;   // refilled if another one lands now
		end
		else if (resp_word.valid)
		begin
			fetch_out <= '{valid: 1'b1, pc: fetched_pc, instr: resp_word.instr};
		end
		else
		begin
			fetch_out <= '{valid: 1'b0, pc: fetched_pc, instr: nop_instr};   // bubble
		end
	end

	always_ff @(posedge clk)
	begin
		if (hold_load)
		begin
			hold_pc    <= fetched_pc;
			hold_instr <= resp_word.instr;
		end
	end

endmodule

//--- rtl/l15_fetch_port.sv
`timescale 1ns/1ps

module l15_fetch_port
	import frontend_pkg::*;
(
	input  logic        clk,
	input  logic        nrst,
	input  logic        stall,
	input  logic [31:0] req_pc,
	output l15_req_t    l15_req,
	input  logic        l15_header_ack,
	input  logic        l15_ack,
	input  l15_resp_t   l15_resp,
	output logic        l15_req_ack,
	output logic        pc_advance,
	output fetch_word_t resp_word
);

	typedef enum logic [1:0]
	{
		st_req,    // request raised, waiting for the header ack
		st_wait,   // request taken, waiting for the fill
		st_resp    // one cycle, pc moves on
	} state_e;

	state_e state;
	state_e state_nxt;

	logic awake;       // set by the first interrupt return
	logic is_int;
	logic is_instr;
	logic req_fire;
	logic resp_fire;

	// sort the incoming return by type
	always_comb
	begin
		is_int   = 1'b0;
		is_instr = 1'b0;
		case (l15_resp.returntype)
			ret_load,
			ret_ifill:
			begin
				is_instr = l15_resp.val;
			end
			ret_int:
			begin
				is_int = l15_resp.val;
			end
			ret_st_ack:
			begin
				is_instr = 1'b0;   // acked and dropped
			end
			default:
			begin
				is_instr = 1'b0;
			end
		endcase
	end

	// sticky until reset
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			awake <= 1'b0;
		end
		else if (is_int)
		begin
			awake <= 1'b1;
		end
	end

	// a fill is header only, so a full ack also means the header was taken
	assign req_fire  = l15_req.val && (l15_header_ack || l15_ack);
	assign resp_fire = (state == st_wait) && is_instr;

	always_comb
	begin
		state_nxt = state;
		case (state)
			st_req:
			begin
				if (req_fire)
				begin
					state_nxt = st_wait;
				end
			end
			st_wait:
			begin
				if (resp_fire)
				begin
					state_nxt = st_resp;
				end
			end
			st_resp:
			begin
				state_nxt = st_req;
			end
			default:
			begin
				state_nxt = st_req;
			end
		endcase
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state <= st_req;
		end
		else
		begin
			state <= state_nxt;
		end
	end

	// fill request, held steady by the pc until the header ack
	always_comb
	begin
		l15_req.val     = (state == st_req) && awake && !stall;
		l15_req.rqtype  = rq_ifill;
		l15_req.size    = fetch_size;
		l15_req.address = req_pc;
	end

	assign l15_req_ack = l15_resp.val;   // every return acked in its own cycle
	assign pc_advance  = (state == st_resp);

	// only word 0 carries the instruction
	assign resp_word.valid = resp_fire;
	assign resp_word.instr = l15_resp.data[0];

endmodule

//--- rtl/pc_unit.sv
`timescale 1ns/1ps

module pc_unit
	import frontend_pkg::*;
(
	input  logic        clk,
	input  logic        nrst,
	input  redirect_t   redirect,
	input  logic        pc_advance,
	output logic [31:0] req_pc,
	output logic [31:0] fetched_pc
);

	logic [31:0] pc;       // address of the current or next fetch
	logic [31:0] pc_nxt;

	// next address, only taken when pc_advance is high
	always_comb
	begin
		unique case (redirect.pc_sel)
			seq:    pc_nxt = pc + 32'd4;
			reset:  pc_nxt = reset_vector;
			target: pc_nxt = redirect.target;
			hold:   pc_nxt = pc;           // refetch same word
		endcase
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			pc <= reset_vector;
		end
		else if (pc_advance)
		begin
			pc <= pc_nxt;
		end
	end

	// pc only moves at the end of the response state, so this copy still
	// holds the address of the request in flight when its instruction
	// comes back, one cycle before the advance
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			fetched_pc <= reset_vector;
		end
		else if (!pc_advance)
		begin
			fetched_pc <= pc;
		end
	end

	assign req_pc = pc;

endmodule

//--- rtl/frontend_pkg.sv
package frontend_pkg;

	// return types from the L1.5 that the fetch port tells apart
	typedef enum logic [3:0]
	{
		ret_load   = 4'b0000,
		ret_ifill  = 4'b0001,
		ret_st_ack = 4'b0100,
		ret_int    = 4'b0111   // interrupt return, also the wake-up event
	} l15_ret_e;

	// request type and size of the one request the front end sends
	typedef enum logic [4:0]
	{
		rq_ifill = 5'b00000
	} l15_rqtype_e;

	typedef enum logic [2:0]
	{
		fetch_size = 3'd4      // one 4-byte word
	} l15_size_e;

	// first fetch address after reset
	localparam logic [31:0] reset_vector = 32'h4000_0000;

	// add x0, x0, x0
	localparam logic [31:0] nop_instr = 32'h0000_0033;

	// next pc selection, sampled in the response state
	typedef enum logic [1:0]
	{
		seq    = 2'd0,
		reset  = 2'd1,
		target = 2'd2,
		hold   = 2'd3
	} pc_sel_e;

	typedef struct packed
	{
		pc_sel_e     pc_sel;
		logic [31:0] target;
	} redirect_t;

	// front end to L1.5
	typedef struct packed
	{
		logic        val;
		logic [4:0]  rqtype;
		logic [2:0]  size;
		logic [31:0] address;
	} l15_req_t;

	// L1.5 to front end, data[0] is word 0
	typedef struct packed
	{
		logic             val;
		logic [3:0]       returntype;
		logic [3:0][31:0] data;
	} l15_resp_t;

	// instruction handed from the port to the output register
	typedef struct packed
	{
		logic        valid;
		logic [31:0] instr;
	} fetch_word_t;

	// word seen by decode
	typedef struct packed
	{
		logic        valid;
		logic [31:0] pc;
		logic [31:0] instr;
	} fetch_out_t;

endpackage
